// ==== Bender.yml ====
package:
  name: acq_trigger

sources:
  - files:
      - acq_pkg.sv
      - config_decoder.sv
      - trigger_manager.sv
      - capture_controller.sv
      - acq_trigger_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - acq_trigger_asserts.sv
      - acq_trigger_tb.sv

// ==== acq_pkg.sv ====
// Shared sizes, reset values and the configuration word layout, imported by the RTL and testbench
package acq_pkg;

  // Trigger and data path sizes
  localparam int unsigned NUM_CHANNELS = 8;
  localparam int unsigned CFG_WIDTH    = 16;
  localparam int unsigned SAMPLE_WIDTH = 16;
  localparam int unsigned LEN_WIDTH    = 12; // Capture length and sample index
  localparam int unsigned MISS_WIDTH   = 8;

  // Capture window length after reset
  localparam logic [LEN_WIDTH-1:0] CAPTURE_LEN_RESET = 12'd16;

  // Values of the trigger mode bit
  localparam logic TRIG_MODE_OR  = 1'b0; // Any enabled line fires
  localparam logic TRIG_MODE_AND = 1'b1; // All enabled lines must be high

  // Values of the target bit, which selects how the rest of the word is read
  localparam logic CFG_TARGET_TRIGGER = 1'b0;
  localparam logic CFG_TARGET_CAPTURE = 1'b1;

  // Trigger settings view of a configuration word
  typedef struct packed {
    logic                                   target;
    logic [CFG_WIDTH-NUM_CHANNELS-3:0]      unused;
    logic                                   mode;   // Bit 8
    logic [NUM_CHANNELS-1:0]                mask;   // Bits 7 to 0
  } cfg_trig_view_t;

  // Capture settings view of a configuration word
  typedef struct packed {
    logic                                   target;
    logic [CFG_WIDTH-LEN_WIDTH-2:0]         unused;
    logic [LEN_WIDTH-1:0]                   length; // Bits 11 to 0
  } cfg_cap_view_t;

  // One 16-bit word with two readings that both keep the target in bit 15
  typedef union packed {
    cfg_trig_view_t trig_view;
    cfg_cap_view_t  cap_view;
  } cfg_word_u;

endpackage

// ==== acq_trigger_asserts.sv ====
// Concurrent checks on the trigger and capture outputs, bound into the top level for simulation
`timescale 1ns/10ps

module acq_trigger_asserts import acq_pkg::*; (
  input logic                 clk,
  input logic                 rst_n,
  input logic [CFG_WIDTH-1:0] cfg_data,
  input logic                 cfg_valid,
  input logic                 trigger_out,
  input logic [LEN_WIDTH-1:0] capture_index,
  input logic                 capture_valid,
  input logic                 capture_done,
  input logic                 capture_busy
);

  cfg_word_u            cfg_word;
  logic [LEN_WIDTH-1:0] length_cfg; // Length last written by a config word
  logic [LEN_WIDTH-1:0] length_win; // Length in force for the open window
  int unsigned          assert_failures = 0;

  assign cfg_word = cfg_data;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      length_cfg <= CAPTURE_LEN_RESET;
    end else if (cfg_valid && (cfg_word.cap_view.target == CFG_TARGET_CAPTURE)) begin
      length_cfg <= cfg_word.cap_view.length;
    end
  end

  // Tracks the setting while idle and freezes once a window opens
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      length_win <= CAPTURE_LEN_RESET;
    end else if (!capture_busy) begin
      length_win <= length_cfg;
    end
  end

  a_quiet_in_reset: assert property (@(posedge clk)
    !rst_n |-> (!trigger_out && !capture_valid && !capture_done))
    else begin
      assert_failures++;
      $error("trigger_out, capture_valid or capture_done went high during reset");
    end

  a_done_with_valid: assert property (@(posedge clk) disable iff (!rst_n)
    capture_done |-> capture_valid)
    else begin
      assert_failures++;
      $error("capture_done was high without capture_valid");
    end

  a_index_in_window: assert property (@(posedge clk) disable iff (!rst_n)
    capture_valid |-> (capture_index < length_win))
    else begin
      assert_failures++;
      $error("capture_index %0d is not below the window length %0d", capture_index, length_win);
    end

endmodule

bind acq_trigger_top acq_trigger_asserts u_acq_trigger_asserts (
  .clk           (clk),
  .rst_n         (rst_n),
  .cfg_data      (cfg_data),
  .cfg_valid     (cfg_valid),
  .trigger_out   (trigger_out),
  .capture_index (capture_index),
  .capture_valid (capture_valid),
  .capture_done  (capture_done),
  .capture_busy  (capture_busy)
);

// ==== acq_trigger_tb.sv ====
// Table-driven testbench for the trigger and capture block, run as the simulation top
`timescale 1ns/10ps

module acq_trigger_tb import acq_pkg::*; ();

  logic                    clk;
  logic                    rst_n;
  logic [NUM_CHANNELS-1:0] triggers_in;
  logic [CFG_WIDTH-1:0]    cfg_data;
  logic                    cfg_valid;
  logic [SAMPLE_WIDTH-1:0] sample_data;
  logic                    sample_valid;
  logic                    trigger_out;
  logic [SAMPLE_WIDTH-1:0] capture_data;
  logic [LEN_WIDTH-1:0]    capture_index;
  logic                    capture_valid;
  logic                    capture_done;
  logic                    capture_busy;
  logic [MISS_WIDTH-1:0]   missed_triggers;

  // Each row holds an optional config word, a trigger burst, a sample run and the expected results
  typedef struct {
    logic                    cfg_en;
    logic [CFG_WIDTH-1:0]    cfg_word;
    logic [NUM_CHANNELS-1:0] pattern;
    int                      hold;    // Cycles each pulse stays high
    int                      pulses;
    int                      samples; // Valid samples driven after the burst
    logic                    gaps;    // Random idle cycles between samples
    logic                    exp_fire;
    int                      exp_caps;
    int                      exp_missed;
  } entry_t;

  entry_t      entries[$];
  logic [31:0] lfsr;
  int          errors;
  int          checks;
  int          cycle_count = 0;
  int          cycle_limit = 0;
  logic        entry_fired;
  int          entry_caps;

  // Reference model state
  logic [NUM_CHANNELS-1:0] m_lines;
  logic                    m_trig;
  logic                    m_prev;
  logic                    m_mode;
  logic [NUM_CHANNELS-1:0] m_mask;
  int                      m_len;
  logic                    m_busy;
  int                      m_win_len;
  int                      m_cnt;
  logic                    m_valid;
  logic                    m_done;
  logic [SAMPLE_WIDTH-1:0] m_data;
  int                      m_index;
  int                      m_missed;

  tb_clock_gen u_tb_clock_gen (.clk(clk));

  acq_trigger_top u_acq_trigger_top (
    .clk             (clk),
    .rst_n           (rst_n),
    .triggers_in     (triggers_in),
    .cfg_data        (cfg_data),
    .cfg_valid       (cfg_valid),
    .sample_data     (sample_data),
    .sample_valid    (sample_valid),
    .trigger_out     (trigger_out),
    .capture_data    (capture_data),
    .capture_index   (capture_index),
    .capture_valid   (capture_valid),
    .capture_done    (capture_done),
    .capture_busy    (capture_busy),
    .missed_triggers (missed_triggers)
  );

  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 32'h80200003; // Taps of x^32 + x^22 + x^2 + x + 1
    end
    return state >> 1;
  endfunction

  function automatic logic next_bit();
    logic b;
    b    = lfsr[0];
    lfsr = lfsr_step(lfsr);
    return b;
  endfunction

  function automatic logic [CFG_WIDTH-1:0] trig_word(input logic mode,
                                                     input logic [NUM_CHANNELS-1:0] mask);
    cfg_word_u w;
    w                  = '0;
    w.trig_view.target = CFG_TARGET_TRIGGER;
    w.trig_view.mode   = mode;
    w.trig_view.mask   = mask;
    return w;
  endfunction

  function automatic logic [CFG_WIDTH-1:0] cap_word(input logic [LEN_WIDTH-1:0] length);
    cfg_word_u w;
    w                 = '0;
    w.cap_view.target = CFG_TARGET_CAPTURE;
    w.cap_view.length = length;
    return w;
  endfunction

  function automatic int entry_cycles(input entry_t e);
    return 1 + e.pulses * (e.hold + 1) + 3 + 2 * e.samples + 4;
  endfunction

  task automatic add_entry(input logic cfg_en, input logic [CFG_WIDTH-1:0] word,
                           input logic [NUM_CHANNELS-1:0] pattern, input int hold,
                           input int pulses, input int samples, input logic gaps,
                           input logic exp_fire, input int exp_caps, input int exp_missed);
    entry_t e;
    e.cfg_en     = cfg_en;
    e.cfg_word   = word;
    e.pattern    = pattern;
    e.hold       = hold;
    e.pulses     = pulses;
    e.samples    = samples;
    e.gaps       = gaps;
    e.exp_fire   = exp_fire;
    e.exp_caps   = exp_caps;
    e.exp_missed = exp_missed;
    entries.push_back(e);
  endtask

  task automatic build_table();
    add_entry(1'b0, '0, 8'hff, 3, 1, 0, 1'b0, 1'b0, 0, 0);         // Reset mask fires nothing
    add_entry(1'b1, cap_word(12'd0), 8'h00, 1, 1, 0, 1'b0, 1'b0, 0, 0);
    add_entry(1'b1, trig_word(TRIG_MODE_OR, 8'h01), 8'hfe, 3, 1, 0, 1'b0, 1'b0, 0, 0);
    add_entry(1'b1, trig_word(TRIG_MODE_OR, 8'h01), 8'h01, 3, 1, 0, 1'b0, 1'b1, 0, 0);
    add_entry(1'b1, trig_word(TRIG_MODE_OR, 8'h0a), 8'h02, 2, 1, 0, 1'b0, 1'b1, 0, 0);
    add_entry(1'b1, trig_word(TRIG_MODE_OR, 8'h0a), 8'hf5, 2, 1, 0, 1'b0, 1'b0, 0, 0);
    add_entry(1'b1, trig_word(TRIG_MODE_AND, 8'h01), 8'hfe, 2, 1, 0, 1'b0, 1'b0, 0, 0);
    add_entry(1'b1, trig_word(TRIG_MODE_AND, 8'h01), 8'h01, 2, 1, 0, 1'b0, 1'b1, 0, 0);
    add_entry(1'b1, trig_word(TRIG_MODE_AND, 8'h90), 8'h6f, 2, 1, 0, 1'b0, 1'b0, 0, 0);
    add_entry(1'b1, trig_word(TRIG_MODE_AND, 8'h90), 8'h7f, 2, 1, 0, 1'b0, 1'b0, 0, 0);
    add_entry(1'b1, trig_word(TRIG_MODE_AND, 8'h90), 8'hef, 2, 1, 0, 1'b0, 1'b0, 0, 0);
    add_entry(1'b1, trig_word(TRIG_MODE_AND, 8'h90), 8'h90, 2, 1, 0, 1'b0, 1'b1, 0, 0);
    add_entry(1'b1, trig_word(TRIG_MODE_AND, 8'h90), 8'hff, 2, 1, 0, 1'b0, 1'b1, 0, 0);
    add_entry(1'b1, trig_word(TRIG_MODE_AND, 8'h00), 8'hff, 2, 1, 0, 1'b0, 1'b0, 0, 0);
    // A length word must leave the AND mode and its mask alone
    add_entry(1'b1, trig_word(TRIG_MODE_AND, 8'h03), 8'h03, 1, 1, 0, 1'b0, 1'b1, 0, 0);
    add_entry(1'b1, cap_word(12'd3), 8'h01, 1, 1, 0, 1'b0, 1'b0, 0, 0);
    add_entry(1'b1, trig_word(TRIG_MODE_OR, 8'h01), 8'h00, 1, 1, 0, 1'b0, 1'b0, 0, 0);
    // The mask set above must survive the length words of these capture windows
    add_entry(1'b1, cap_word(12'd1), 8'h01, 1, 1, 1, 1'b0, 1'b1, 1, 0);
    add_entry(1'b1, cap_word(12'd5), 8'h01, 2, 1, 5, 1'b1, 1'b1, 5, 0);
    add_entry(1'b1, cap_word(12'd16), 8'h01, 1, 1, 16, 1'b1, 1'b1, 16, 0);
    add_entry(1'b1, trig_word(TRIG_MODE_OR, 8'h03), 8'h02, 1, 1, 16, 1'b0, 1'b1, 16, 0);
    // A window left open, then pulses that arrive while it is busy
    add_entry(1'b0, '0, 8'h01, 1, 1, 4, 1'b0, 1'b1, 4, 0);
    add_entry(1'b1, cap_word(12'd2), 8'h01, 1, 3, 0, 1'b0, 1'b1, 0, 3);
    add_entry(1'b0, '0, 8'h01, 6, 1, 0, 1'b0, 1'b1, 0, 4);         // Held high counts once
    add_entry(1'b0, '0, 8'h01, 1, 260, 0, 1'b0, 1'b1, 0, 255);
    add_entry(1'b0, '0, 8'h00, 1, 1, 12, 1'b1, 1'b0, 12, 255);     // Open window keeps 16
    add_entry(1'b0, '0, 8'h01, 1, 1, 2, 1'b0, 1'b1, 2, 255);
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("mismatch %s: got 0x%0h, expected 0x%0h at %0t", name, actual, expected, $time);
    end
  endtask

  task automatic model_reset();
    m_lines   = '0;
    m_trig    = 1'b0;
    m_prev    = 1'b0;
    m_mode    = TRIG_MODE_OR;
    m_mask    = '0;
    m_len     = CAPTURE_LEN_RESET;
    m_busy    = 1'b0;
    m_win_len = 0;
    m_cnt     = 0;
    m_valid   = 1'b0;
    m_done    = 1'b0;
    m_data    = '0;
    m_index   = 0;
    m_missed  = 0;
  endtask

  // Advances the model by one rising edge, each stage reading what stood before the edge
  task automatic model_edge();
    cfg_word_u w;
    logic      rise;
    rise = m_trig && !m_prev;
    if (m_busy && rise && (m_missed < (1 << MISS_WIDTH) - 1)) begin
      m_missed++;
    end
    m_prev  = m_trig;
    m_valid = 1'b0;
    m_done  = 1'b0;
    if (!m_busy && m_trig && (m_len != 0)) begin
      m_busy    = 1'b1;
      m_win_len = m_len;
      m_cnt     = 0;
    end else if (m_busy && sample_valid) begin
      m_valid = 1'b1;
      m_data  = sample_data;
      m_index = m_cnt;
      m_cnt++;
      if (m_cnt == m_win_len) begin
        m_done = 1'b1;
        m_busy = 1'b0;
      end
    end
    if (m_mode == TRIG_MODE_AND) begin
      m_trig = (m_mask != '0) && ((m_lines & m_mask) == m_mask);
    end else begin
      m_trig = (m_lines & m_mask) != '0;
    end
    m_lines = triggers_in;
    w = cfg_data;
    if (cfg_valid && (w.cap_view.target == CFG_TARGET_CAPTURE)) begin
      m_len = w.cap_view.length;
    end else if (cfg_valid) begin
      m_mode = w.trig_view.mode;
      m_mask = w.trig_view.mask;
    end
  endtask

  task automatic compare_outputs();
    check_value("trigger_out", trigger_out, m_trig);
    check_value("capture_busy", capture_busy, m_busy);
    check_value("capture_valid", capture_valid, m_valid);
    check_value("capture_done", capture_done, m_done);
    check_value("missed_triggers", missed_triggers, m_missed);
    if (m_valid) begin
      check_value("capture_data", capture_data, m_data);
      check_value("capture_index", capture_index, m_index);
    end
    if (trigger_out === 1'b1) entry_fired = 1'b1;
    if (capture_valid === 1'b1) entry_caps++;
  endtask

  // Outputs are compared 1 ns after the edge, where they have settled
  task automatic tick();
    @(posedge clk);
    model_edge();
    #1;
    compare_outputs();
  endtask

  task automatic drive(input logic [NUM_CHANNELS-1:0] pattern, input logic cfg_v,
                       input logic [CFG_WIDTH-1:0] word, input logic samp_v);
    logic [SAMPLE_WIDTH-1:0] value;
    value = '0;
    if (samp_v) begin
      repeat (SAMPLE_WIDTH) value = {value[SAMPLE_WIDTH-2:0], next_bit()};
    end
    triggers_in  = pattern;
    cfg_valid    = cfg_v;
    cfg_data     = word;
    sample_valid = samp_v;
    sample_data  = value;
  endtask

  task automatic apply_entry(input int idx);
    entry_t e;
    int     sent;
    logic   take;
    e           = entries[idx];
    entry_fired = 1'b0;
    entry_caps  = 0;
    if (e.cfg_en) begin
      drive('0, 1'b1, e.cfg_word, 1'b0);
      tick();
    end
    repeat (e.pulses) begin
      repeat (e.hold) begin
        drive(e.pattern, 1'b0, '0, 1'b0);
        tick();
      end
      drive('0, 1'b0, '0, 1'b0); // One low cycle splits the pulses
      tick();
    end
    repeat (3) begin
      drive('0, 1'b0, '0, 1'b0);
      tick();
    end
    sent = 0;
    while (sent < e.samples) begin
      take = e.gaps ? next_bit() : 1'b1;
      drive('0, 1'b0, '0, take);
      tick();
      if (take) sent++;
    end
    repeat (4) begin
      drive('0, 1'b0, '0, 1'b0);
      tick();
    end
    check_value("trigger_out fired", entry_fired, e.exp_fire);
    check_value("capture count", entry_caps, e.exp_caps);
    check_value("missed_triggers", missed_triggers, e.exp_missed);
  endtask

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("Timeout: the table did not finish within %0d clock cycles", cycle_limit);
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    int worst;
    rst_n        = 1'b1;
    triggers_in  = '0;
    cfg_data     = '0;
    cfg_valid    = 1'b0;
    sample_data  = '0;
    sample_valid = 1'b0;
    lfsr         = 32'h5d2853a3;
    errors       = 0;
    checks       = 0;
    build_table();
    worst = 0;
    foreach (entries[i]) begin
      if (entry_cycles(entries[i]) > worst) worst = entry_cycles(entries[i]);
    end
    cycle_limit = entries.size() * worst * 4;
    #1 rst_n = 1'b0;
    repeat (16) @(posedge clk);
    #1 rst_n = 1'b1;
    model_reset();
    check_value("trigger_out", trigger_out, 1'b0);
    check_value("capture_valid", capture_valid, 1'b0);
    check_value("capture_done", capture_done, 1'b0);
    check_value("capture_busy", capture_busy, 1'b0);
    check_value("missed_triggers", missed_triggers, 0);
    foreach (entries[i]) apply_entry(i);
    errors = errors + u_acq_trigger_top.u_acq_trigger_asserts.assert_failures;
    $display("Summary: %0d checks, %0d errors, %0d assertion failures", checks, errors,
             u_acq_trigger_top.u_acq_trigger_asserts.assert_failures);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== acq_trigger_top.sv ====
// Top level that wires the config decoder, trigger combiner and capture controller together
`timescale 1ns/10ps

module acq_trigger_top import acq_pkg::*; (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [NUM_CHANNELS-1:0] triggers_in,
  input  logic [CFG_WIDTH-1:0]    cfg_data,
  input  logic                    cfg_valid,
  input  logic [SAMPLE_WIDTH-1:0] sample_data,
  input  logic                    sample_valid,
  output logic                    trigger_out,
  output logic [SAMPLE_WIDTH-1:0] capture_data,
  output logic [LEN_WIDTH-1:0]    capture_index,
  output logic                    capture_valid,
  output logic                    capture_done,
  output logic                    capture_busy,
  output logic [MISS_WIDTH-1:0]   missed_triggers
);

  // Settings held by the decoder
  logic                    trig_mode;
  logic [NUM_CHANNELS-1:0] trig_mask;
  logic [LEN_WIDTH-1:0]    capture_length;

  config_decoder u_config_decoder (
    .clk            (clk),
    .rst_n          (rst_n),
    .cfg_data       (cfg_data),
    .cfg_valid      (cfg_valid),
    .trig_mode      (trig_mode),
    .trig_mask      (trig_mask),
    .capture_length (capture_length)
  );

  trigger_manager u_trigger_manager (
    .clk         (clk),
    .rst_n       (rst_n),
    .triggers_in (triggers_in),
    .trig_mode   (trig_mode),
    .trig_mask   (trig_mask),
    .trigger_out (trigger_out)
  );

  // The trigger level is both a top-level output and the window start request
  capture_controller u_capture_controller (
    .clk             (clk),
    .rst_n           (rst_n),
    .trigger_out     (trigger_out),
    .capture_length  (capture_length),
    .sample_data     (sample_data),
    .sample_valid    (sample_valid),
    .capture_data    (capture_data),
    .capture_index   (capture_index),
    .capture_valid   (capture_valid),
    .capture_done    (capture_done),
    .capture_busy    (capture_busy),
    .missed_triggers (missed_triggers)
  );

endmodule

// ==== capture_controller.sv ====
// Capture window controller that forwards indexed samples after a trigger and counts missed triggers
`timescale 1ns/10ps

module capture_controller import acq_pkg::*; (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    trigger_out,
  input  logic [LEN_WIDTH-1:0]    capture_length,
  input  logic [SAMPLE_WIDTH-1:0] sample_data,
  input  logic                    sample_valid,
  output logic [SAMPLE_WIDTH-1:0] capture_data,
  output logic [LEN_WIDTH-1:0]    capture_index,
  output logic                    capture_valid,
  output logic                    capture_done,
  output logic                    capture_busy,
  output logic [MISS_WIDTH-1:0]   missed_triggers
);

  logic [LEN_WIDTH-1:0] capture_len_q; // Length in force for the current window
  logic [LEN_WIDTH-1:0] sample_count;  // Index of the next sample in the window
  logic                 trigger_prev;
  logic                 trigger_rise;
  logic                 window_start;
  logic                 last_sample;
  logic                 take_sample;

  assign trigger_rise = trigger_out && !trigger_prev;

  // A zero length keeps the controller idle whatever the trigger does
  assign window_start = !capture_busy && trigger_out && (capture_length != '0);

  assign take_sample = capture_busy && sample_valid;
  assign last_sample = (sample_count == capture_len_q - LEN_WIDTH'(1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      trigger_prev <= 1'b0;
    end else begin
      trigger_prev <= trigger_out;
    end
  end

  // Idle/busy FSM with capture_busy as its state bit
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      capture_busy  <= 1'b0;
      capture_len_q <= '0;
      sample_count  <= '0;
      capture_valid <= 1'b0;
      capture_done  <= 1'b0;
    end else begin
      capture_valid <= 1'b0;
      capture_done  <= 1'b0;
      if (window_start) begin
        capture_busy  <= 1'b1;
        capture_len_q <= capture_length; // Later config words leave this window alone
        sample_count  <= '0;
      end else if (take_sample) begin
        capture_valid <= 1'b1;
        if (last_sample) begin
          capture_done <= 1'b1;
          capture_busy <= 1'b0; // Free for a trigger on the next edge
        end else begin
          sample_count <= sample_count + LEN_WIDTH'(1);
        end
      end
    end
  end

  // Payload registers load with each accepted sample
  always_ff @(posedge clk) begin
    if (take_sample) begin
      capture_data  <= sample_data;
      capture_index <= sample_count;
    end
  end

  // Each new trigger edge seen during a window is lost, so count it
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      missed_triggers <= '0;
    end else if (capture_busy && trigger_rise && (missed_triggers != '1)) begin
      missed_triggers <= missed_triggers + MISS_WIDTH'(1); // Holds at all ones
    end
  end

endmodule

// ==== config_decoder.sv ====
// Configuration word decoder that holds trigger mode, trigger mask and capture length settings
`timescale 1ns/10ps

module config_decoder import acq_pkg::*; (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [CFG_WIDTH-1:0]    cfg_data,
  input  logic                    cfg_valid,
  output logic                    trig_mode,
  output logic [NUM_CHANNELS-1:0] trig_mask,
  output logic [LEN_WIDTH-1:0]    capture_length
);

  cfg_word_u cfg_word;
  logic      cfg_target;
  logic      trig_wr;
  logic      cap_wr;

  // The incoming word is looked at through whichever view the target selects
  assign cfg_word = cfg_data;

  // Both views put the target in the same place, so either one serves here
  assign cfg_target = cfg_word.trig_view.target;

  assign trig_wr = cfg_valid && (cfg_target == CFG_TARGET_TRIGGER);
  assign cap_wr  = cfg_valid && (cfg_target == CFG_TARGET_CAPTURE);

  // Trigger settings only change on a trigger-target word
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      trig_mode <= TRIG_MODE_OR;
      trig_mask <= '0;           // With no line enabled nothing can fire
    end else if (trig_wr) begin
      trig_mode <= cfg_word.trig_view.mode;
      trig_mask <= cfg_word.trig_view.mask;
    end
  end

  // Window length only changes on a capture-target word
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      capture_length <= CAPTURE_LEN_RESET;
    end else if (cap_wr) begin
      capture_length <= cfg_word.cap_view.length; // Zero turns capture off
    end
  end

endmodule

// ==== filelist.f ====
acq_pkg.sv
config_decoder.sv
trigger_manager.sv
capture_controller.sv
acq_trigger_top.sv
tb_clock_gen.sv
acq_trigger_asserts.sv
acq_trigger_tb.sv

// ==== tb_clock_gen.sv ====
// Free-running testbench clock with an 8 ns period, instantiated once by the testbench top
`timescale 1ns/10ps

module tb_clock_gen (
  output logic clk
);

  // Starts low so the first rising edge falls at 4 ns
  initial begin
    clk = 1'b0;
    forever begin
      #4 clk = ~clk; // Half of the 8 ns period
    end
  end

endmodule

// ==== trigger_manager.sv ====
// Trigger combiner that registers the input lines and forms the masked OR or AND trigger level
`timescale 1ns/10ps

module trigger_manager import acq_pkg::*; (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [NUM_CHANNELS-1:0] triggers_in,
  input  logic                    trig_mode,
  input  logic [NUM_CHANNELS-1:0] trig_mask,
  output logic                    trigger_out
);

  logic [NUM_CHANNELS-1:0] triggers_q;
  logic [NUM_CHANNELS-1:0] enabled_high;
  logic                    any_enabled;
  logic                    or_level;
  logic                    and_level;
  logic                    trigger_next;

  // First stage captures the raw lines, which are external and may be asynchronous
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      triggers_q <= '0;
    end else begin
      triggers_q <= triggers_in;
    end
  end

  assign enabled_high = triggers_q & trig_mask;
  assign any_enabled  = |trig_mask;

  // OR mode fires on any enabled line that is high
  assign or_level = |enabled_high;

  // Lines outside the mask count as high for the AND, but an empty mask never fires
  assign and_level = any_enabled && (&(triggers_q | ~trig_mask));

  always_comb begin
    if (trig_mode == TRIG_MODE_AND) begin
      trigger_next = and_level;
    end else begin
      trigger_next = or_level; // TRIG_MODE_OR
    end
  end

  // Second stage gives the registered trigger level
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      trigger_out <= 1'b0;
    end else begin
      trigger_out <= trigger_next;
    end
  end

endmodule
